//--- src.f
ram_pkg.sv
access_pkg.sv
request_arbiter.sv
byte_sequencer.sv
load_assembler.sv
mem_ctrl.sv
tb_clock_gen.sv
tb_ram_model.sv
tb_mem_ctrl.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_mem_ctrl
FILELIST  = src.f
OBJDIR    = obj_dir

PASS_MSG  = *** TEST PASSED ***

.PHONY: compile run clean

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# output goes to the terminal, the search decides the exit status
run: compile
	out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

//--- tb_mem_ctrl.sv
`timescale 1ns/1ps

module tb_mem_ctrl import access_pkg::*, ram_pkg::*; ();

    // the tests take roughly 200 cycles
    localparam int max_cycles = 2000;

    logic              clk;
    logic              rst;
    logic              flush;
    logic              lsb_req;
    logic              ic_req;
    access_req_t       lsb_access;
    logic [word_w-1:0] ic_addr;
    logic [word_w-1:0] lsb_rdata;
    logic [word_w-1:0] ic_instr;
    logic              lsb_load_done;
    logic              lsb_store_done;
    logic              ic_done;
    mem_bus_t          ram_bus;
    logic [byte_w-1:0] ram_rdata;
    int                mismatch_count = 0;
    int                other_count = 0;
    int                cycle_count = 0;

    tb_clock_gen clock_gen (.clk(clk), .rst(rst));
    tb_ram_model ram (.clk(clk), .ram_bus(ram_bus), .ram_rdata(ram_rdata));
    mem_ctrl DUT (.*);

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout after %0d cycles, a transfer never completed", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond)
        else begin
            $display("ERROR at %0t: %s", $time, what);
            other_count++;
        end
    endtask

    function automatic access_req_t make_req(input op_e op, input len_e len,
                                             input logic [31:0] addr, input logic [31:0] wdata);
        access_req_t req;
        req.op    = op;
        req.len   = len;
        req.addr  = addr;
        req.wdata = wdata;
        return req;
    endfunction

    // little-endian word from the shadow with zeros above n bytes
    function automatic logic [31:0] expected_word(input logic [31:0] addr, input int n);
        logic [31:0] word;
        logic [31:0] a;
        word = '0;
        for (int k = 0; k < n; k++) begin
            a = addr + k;
            word[k*8 +: 8] = ram.shadow[a[11:0]];
        end
        return word;
    endfunction

    task automatic check_ram_region(input logic [11:0] lo, input int n);
        logic [11:0] a;
        for (int k = 0; k < n; k++) begin
            a = lo + 12'(k);
            check_value($sformatf("ram.mem[%h]", a), 32'(ram.shadow[a]), 32'(ram.mem[a]));
        end
    endtask

    // one load/store buffer access with done latency counted from the first enable cycle
    task automatic run_lsb(input op_e op, input len_e len, input logic [31:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
        int    cyc;
        int    first_en;
        logic  done;
        string done_name;
        cyc      = 0;
        first_en = -1;
        done     = 1'b0;
        if (op == op_load) begin
            done_name = "lsb_load_done latency";
        end else begin
            done_name = "lsb_store_done latency";
        end
        @(posedge clk);
        lsb_access <= make_req(op, len, addr, wdata);
        lsb_req    <= 1'b1;
        while (!done) begin
            @(negedge clk);
            cyc++;
            if (ram_bus.enable && first_en < 0) begin
                first_en = cyc;
            end
            done = (op == op_load) ? lsb_load_done : lsb_store_done;
        end
        rdata = lsb_rdata;
        @(posedge clk);
        lsb_req <= 1'b0;
        check_value(done_name, int'(len) + ((op == op_load) ? 1 : 0), cyc - first_en);
        if (op == op_store) begin
            for (int k = 0; k < int'(len); k++) begin
                ram.note_store(addr + k, wdata[k*8 +: 8]);
            end
        end
    endtask

    task automatic run_fetch(input logic [31:0] addr, output logic [31:0] instr);
        logic done;
        logic lsb_seen;
        done     = 1'b0;
        lsb_seen = 1'b0;
        @(posedge clk);
        ic_addr <= addr;
        ic_req  <= 1'b1;
        while (!done) begin
            @(negedge clk);
            done     = ic_done;
            lsb_seen = lsb_seen | lsb_load_done;
        end
        instr = ic_instr;
        @(posedge clk);
        ic_req <= 1'b0;
        check_true(!lsb_seen, "lsb_load_done pulsed during an instruction fetch");
    endtask

    task automatic test_reset_and_word;
        logic [31:0] data;
        @(negedge clk);
        check_value("ram_bus.enable", 32'd0, 32'(ram_bus.enable));
        check_value("lsb_load_done", 32'd0, 32'(lsb_load_done));
        check_value("lsb_store_done", 32'd0, 32'(lsb_store_done));
        check_value("ic_done", 32'd0, 32'(ic_done));
        run_lsb(op_store, len_word, 32'h100, 32'hcafe_f00d, data);
        check_value("ram.mem[100]", 32'h0d, 32'(ram.mem[12'h100]));
        check_value("ram.mem[103]", 32'hca, 32'(ram.mem[12'h103]));
        check_ram_region(12'h0fe, 8);
        run_lsb(op_load, len_word, 32'h100, '0, data);
        check_value("lsb_rdata", 32'hcafe_f00d, data);
    endtask

    task automatic test_short_access;
        logic [31:0] data;
        run_lsb(op_store, len_half, 32'h201, 32'h1234_beef, data);
        check_ram_region(12'h1ff, 6);
        run_lsb(op_store, len_byte, 32'h300, 32'h0000_00a5, data);
        check_ram_region(12'h2fe, 5);
        run_lsb(op_load, len_half, 32'h2ff, '0, data);
        check_value("lsb_rdata", expected_word(32'h2ff, 2), data);
        run_lsb(op_load, len_byte, 32'h202, '0, data);
        check_value("lsb_rdata", expected_word(32'h202, 1), data);
    endtask

    task automatic test_fetch;
        logic [31:0] instr;
        run_fetch(32'h800, instr);
        check_value("ic_instr", expected_word(32'h800, 4), instr);
    endtask

    task automatic test_priority;
        logic        lsb_seen;
        logic        ic_seen;
        int          n;
        int          lsb_at;
        int          ic_at;
        logic [31:0] lsb_word;
        logic [31:0] ic_word;
        lsb_seen = 1'b0;
        ic_seen  = 1'b0;
        n        = 0;
        lsb_at   = 0;
        ic_at    = 0;
        lsb_word = '0;
        ic_word  = '0;
        @(posedge clk);
        lsb_access <= make_req(op_load, len_word, 32'h900, '0);
        lsb_req    <= 1'b1;
        ic_addr    <= 32'ha00;
        ic_req     <= 1'b1;
        while (!(lsb_seen && ic_seen)) begin
            @(negedge clk);
            n++;
            if (lsb_load_done && !lsb_seen) begin
                lsb_seen = 1'b1;
                lsb_at   = n;
                lsb_word = lsb_rdata;
            end
            if (ic_done && !ic_seen) begin
                ic_seen = 1'b1;
                ic_at   = n;
                ic_word = ic_instr;
            end
            @(posedge clk);
            if (lsb_seen) lsb_req <= 1'b0;
            if (ic_seen) ic_req <= 1'b0;
        end
        check_true(lsb_at < ic_at, "ic_done arrived before lsb_load_done");
        check_value("lsb_rdata", expected_word(32'h900, 4), lsb_word);
        check_value("ic_instr", expected_word(32'ha00, 4), ic_word);
    endtask

    // the N+1 latency itself is checked inside run_lsb
    task automatic test_load_latency;
        logic [31:0] data;
        run_lsb(op_load, len_byte, 32'hb00, '0, data);
        check_value("lsb_rdata", expected_word(32'hb00, 1), data);
        run_lsb(op_load, len_half, 32'hb11, '0, data);
        check_value("lsb_rdata", expected_word(32'hb11, 2), data);
        run_lsb(op_load, len_word, 32'hb23, '0, data);
        check_value("lsb_rdata", expected_word(32'hb23, 4), data);
    endtask

    task automatic test_flush;
        logic [31:0] data;
        logic        seen;
        seen = 1'b0;
        @(posedge clk);
        lsb_access <= make_req(op_load, len_word, 32'hc00, '0);
        lsb_req    <= 1'b1;
        while (!ram_bus.enable) @(negedge clk);
        // abandon the load in the middle of its transfer
        @(posedge clk);
        flush   <= 1'b1;
        lsb_req <= 1'b0;
        @(posedge clk);
        flush <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            seen = seen | lsb_load_done | ic_done | ram_bus.enable;
        end
        check_true(!seen, "done pulse or RAM access after flush");
        run_lsb(op_load, len_word, 32'hc00, '0, data);
        check_value("lsb_rdata", expected_word(32'hc00, 4), data);
    endtask

    initial begin
        flush      = 1'b0;
        lsb_req    = 1'b0;
        ic_req     = 1'b0;
        lsb_access = '0;
        ic_addr    = '0;
        @(negedge rst);
        test_reset_and_word();
        test_short_access();
        test_fetch();
        test_priority();
        test_load_latency();
        test_flush();
        repeat (2) @(posedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb_ram_model.sv
`timescale 1ns/1ps

module tb_ram_model import ram_pkg::*; (
    input  logic              clk,
    input  mem_bus_t          ram_bus,
    output logic [byte_w-1:0] ram_rdata
);

    // 4 KB, upper address bits ignored
    localparam int depth = 4096;

    logic [byte_w-1:0] mem    [depth];
    // expected contents, only the testbench writes it
    logic [byte_w-1:0] shadow [depth];
    int                seed;

    initial begin
        seed      = 32'h9fe8;
        ram_rdata = '0;
        for (int i = 0; i < depth; i++) begin
            mem[i]    = byte_w'($random(seed));
            shadow[i] = mem[i];
        end
    end

    // read data one cycle after the address
    always @(posedge clk) begin
        if (ram_bus.enable) begin
            if (ram_bus.write) begin
                mem[ram_bus.addr[11:0]] <= ram_bus.wdata;
            end else begin
                ram_rdata <= mem[ram_bus.addr[11:0]];
            end
        end
    end

    task automatic note_store(input logic [addr_w-1:0] addr, input logic [byte_w-1:0] data);
        shadow[addr[11:0]] = data;
    endtask

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period  = 5,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl import access_pkg::*, ram_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    // load/store buffer
    input  logic              lsb_req,
    input  access_req_t       lsb_access,
    output logic [word_w-1:0] lsb_rdata,
    output logic              lsb_load_done,
    output logic              lsb_store_done,
    // instruction cache
    input  logic              ic_req,
    input  logic [word_w-1:0] ic_addr,
    output logic [word_w-1:0] ic_instr,
    output logic              ic_done,
    // byte RAM
    output mem_bus_t          ram_bus,
    input  logic [byte_w-1:0] ram_rdata
);

    logic                         start;
    logic                         idle;
    access_req_t                  cur_req;
    src_e                         cur_src;
    logic                         cap_valid;
    logic                         cap_last;
    logic [$clog2(max_bytes)-1:0] cap_index;

    request_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .lsb_req    (lsb_req),
        .ic_req     (ic_req),
        .lsb_access (lsb_access),
        .ic_addr    (ic_addr),
        .idle       (idle),
        .start      (start),
        .cur_req    (cur_req),
        .cur_src    (cur_src)
    );

    byte_sequencer u_sequencer (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .start          (start),
        .cur_req        (cur_req),
        .ram_bus        (ram_bus),
        .idle           (idle),
        .cap_valid      (cap_valid),
        .cap_last       (cap_last),
        .cap_index      (cap_index),
        .lsb_store_done (lsb_store_done)
    );

    load_assembler u_assembler (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .cur_src       (cur_src),
        .cap_valid     (cap_valid),
        .cap_last      (cap_last),
        .cap_index     (cap_index),
        .ram_rdata     (ram_rdata),
        .lsb_rdata     (lsb_rdata),
        .ic_instr      (ic_instr),
        .lsb_load_done (lsb_load_done),
        .ic_done       (ic_done)
    );

endmodule

//--- load_assembler.sv
`timescale 1ns/1ps

module load_assembler import access_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  src_e                         cur_src,
    input  logic                         cap_valid,
    input  logic                         cap_last,
    input  logic [$clog2(max_bytes)-1:0] cap_index,
    input  logic [7:0]                   ram_rdata,
    output logic [word_w-1:0]            lsb_rdata,
    output logic [word_w-1:0]            ic_instr,
    output logic                         lsb_load_done,
    output logic                         ic_done
);

    logic [word_w-1:0] word_q;
    logic [word_w-1:0] word_next;
    logic              finish;

    // lane 0 starts a fresh word, upper lanes of short loads stay zero
    always_comb begin
        word_next = (cap_index == '0) ? '0 : word_q;
        word_next[cap_index*8 +: 8] = ram_rdata;
    end

    assign finish = cap_valid && cap_last;

    always_ff @(posedge clk) begin
        if (cap_valid) begin
            word_q <= word_next;
        end
        // result goes only to the owner of the transfer
        if (finish) begin
            if (cur_src == src_lsb) begin
                lsb_rdata <= word_next;
            end else begin
                ic_instr <= word_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            lsb_load_done <= 1'b0;
            ic_done       <= 1'b0;
        end else begin
            lsb_load_done <= finish && (cur_src == src_lsb);
            ic_done       <= finish && (cur_src == src_icache);
        end
    end

endmodule

//--- byte_sequencer.sv
`timescale 1ns/1ps

module byte_sequencer import access_pkg::*, ram_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         start,
    input  access_req_t                  cur_req,
    output mem_bus_t                     ram_bus,
    output logic                         idle,
    output logic                         cap_valid,
    output logic                         cap_last,
    output logic [$clog2(max_bytes)-1:0] cap_index,
    output logic                         lsb_store_done
);

    typedef enum logic [1:0] {
        seq_idle,
        seq_issue,
        seq_drain,
        seq_finish
    } seq_state_e;

    seq_state_e                   state;
    logic [$clog2(max_bytes)-1:0] count;
    logic [2:0]                   n_bytes;
    logic                         issuing;
    logic                         is_load;
    logic                         last_byte;

    // byte 0 goes out in the start cycle itself
    assign issuing   = start || (state == seq_issue);
    assign is_load   = (cur_req.op == op_load);
    assign n_bytes   = cur_req.len;
    assign last_byte = ({1'b0, count} + 3'd1) == n_bytes;

    // busy from start through the done cycle
    assign idle = (state == seq_idle) && !start;

    always_comb begin
        ram_bus.addr   = addr_w'(cur_req.addr) + addr_w'(count);
        ram_bus.wdata  = cur_req.wdata[count*byte_w +: byte_w];
        ram_bus.write  = issuing && !is_load;
        ram_bus.enable = issuing;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state          <= seq_idle;
            count          <= '0;
            cap_valid      <= 1'b0;
            cap_last       <= 1'b0;
            lsb_store_done <= 1'b0;
        end else begin
            // capture strobes trail the address by one cycle
            cap_valid      <= issuing && is_load;
            cap_last       <= issuing && is_load && last_byte;
            lsb_store_done <= 1'b0;
            case (state)
                seq_idle, seq_issue: begin
                    if (issuing) begin
                        if (last_byte) begin
                            count <= '0;
                            if (is_load) begin
                                state <= seq_drain;
                            end else begin
                                state          <= seq_finish;
                                lsb_store_done <= 1'b1;
                            end
                        end else begin
                            count <= count + 1'b1;
                            state <= seq_issue;
                        end
                    end
                end
                // last read byte is on ram_rdata
                seq_drain:  state <= seq_finish;
                // done pulse cycle
                seq_finish: state <= seq_idle;
                default:    state <= seq_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        cap_index <= count;
    end

endmodule

//--- request_arbiter.sv
`timescale 1ns/1ps

module request_arbiter import access_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              lsb_req,
    input  logic              ic_req,
    input  access_req_t       lsb_access,
    input  logic [word_w-1:0] ic_addr,
    input  logic              idle,
    output logic              start,
    output access_req_t       cur_req,
    output src_e              cur_src
);

    access_req_t pick_req;
    src_e        pick_src;
    logic        accept;

    // load/store buffer always wins over the instruction cache
    always_comb begin
        if (lsb_req) begin
            pick_req = lsb_access;
            pick_src = src_lsb;
        end else begin
            // fetch is a plain word load
            pick_req.op    = op_load;
            pick_req.len   = len_word;
            pick_req.addr  = ic_addr;
            pick_req.wdata = '0;
            pick_src       = src_icache;
        end
    end

    // idle stays low through the done cycle, so no second grant
    assign accept = idle && (lsb_req || ic_req);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            start <= 1'b0;
        end else begin
            start <= accept;
        end
    end

    // held for the whole transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_req <= pick_req;
            cur_src <= pick_src;
        end
    end

endmodule

//--- access_pkg.sv
package access_pkg;

    // requester-side data width and bytes per word
    localparam int word_w    = 32;
    localparam int max_bytes = 4;

    typedef enum logic {
        op_load,
        op_store
    } op_e;

    // encoding equals the byte count of the access
    typedef enum logic [2:0] {
        len_byte = 3'd1,
        len_half = 3'd2,
        len_word = 3'd4
    } len_e;

    // which requester owns the current transfer
    typedef enum logic {
        src_lsb,
        src_icache
    } src_e;

    // one access as seen by the controller, 68 bits
    typedef struct packed {
        op_e               op;
        len_e              len;
        logic [word_w-1:0] addr;
        // store data, little-endian, only the low len bytes matter
        logic [word_w-1:0] wdata;
    } access_req_t;

endpackage

//--- ram_pkg.sv
package ram_pkg;

    // byte-wide RAM, read data comes back one cycle after the address
    localparam int addr_w = 32;
    localparam int byte_w = 8;

    // request side of the RAM port, 42 bits
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [byte_w-1:0] wdata;
        // 1 for write, 0 for read
        logic              write;
        logic              enable;
    } mem_bus_t;

endpackage
